// File: include/snake_defines.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// constants for the snake game core
// grid size, body capacity, start position and the register map
// included by the package, the RTL and the testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef SNAKE_DEFINES_SVH
`define SNAKE_DEFINES_SVH

// highest coordinate on the 16x16 grid
// coordinates 0 and GRID_MAX are border cells
`define GRID_MAX 15

// body capacity in segments
`define MAX_LENGTH 32

// head position after start
`define START_X 4
`define START_Y 8

// AXI4-Lite byte offsets
`define REG_CTRL     8'h00
`define REG_STATUS   8'h04
`define REG_HEAD     8'h08
`define REG_APPLE    8'h0C
`define REG_OBSTACLE 8'h10
`define REG_SCORE    8'h14

`endif

// File: source/snake_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types of the snake game core
// imported by the control interface, the RTL and the testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "snake_defines.svh"

package snake_pkg;

  // move direction
  // up decreases y
  typedef enum logic [1:0] {
    dirUp,
    dirDown,
    dirLeft,
    dirRight
  } dir_e;

  // game FSM states
  typedef enum logic [1:0] {
    stateIdle,
    statePlaying,
    stateOver,
    stateWon
  } gameState_e;

  // one grid cell packed into a byte
  typedef struct packed {
    logic [3:0] x;
    logic [3:0] y;
  } cell_t;

  // index 0 holds the head
  typedef cell_t [`MAX_LENGTH-1:0] bodyArray_t;

endpackage

`default_nettype wire

// File: source/game_ctrl_if.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// control and status bundle between the register block and the game
// one modport per block, instanced once in the top level
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

interface gameCtrlIf import snake_pkg::*; ();

  // from the register block
  logic       start;
  logic       step;
  dir_e       dir;
  logic       obstacleEn;

  // from the body controller
  cell_t      head;
  logic [5:0] length;
  logic       moved;

  // from the apple placer
  cell_t      apple;
  logic       appleValid;
  cell_t      obstacle;
  logic       obstacleValid;

  // from the judge
  gameState_e      state;
  logic [7:0]      stepCount;
  logic            eat;
  logic [2:0][3:0] bcdScore;

  modport regs (
    output start, step, dir, obstacleEn,
    input  head, length, apple, appleValid, obstacle, obstacleValid,
    input  state, stepCount, bcdScore
  );

  modport body (
    input  start, step, dir, state,
    output head, length, moved
  );

  modport placer (
    input  start, eat, obstacleEn, length,
    output apple, appleValid, obstacle, obstacleValid
  );

  modport judge (
    input  start, moved, head, length, apple, appleValid, obstacle, obstacleValid,
    output state, stepCount, eat, bcdScore
  );

endinterface

`default_nettype wire

// File: source/axil_game_regs.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite slave for the snake core
// CTRL write issues start and step pulses and holds direction and
// obstacle enable, the other words report game state read-only
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "snake_defines.svh"

module axil_game_regs import snake_pkg::*; (
  input  logic        hwclk,
  input  logic        rst,
  // write address
  input  logic [7:0]  awaddr,
  input  logic        awvalid,
  output logic        awready,
  // write data
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  input  logic        wvalid,
  output logic        wready,
  // write response
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  // read address
  input  logic [7:0]  araddr,
  input  logic        arvalid,
  output logic        arready,
  // read data
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready,
  gameCtrlIf.regs     ctrl
);

  localparam logic [1:0] respOkay   = 2'b00;
  localparam logic [1:0] respSlvErr = 2'b10;

  logic        writeFire;
  logic        readFire;
  logic        writeMapped;
  logic        readMapped;
  logic [31:0] readWord;
  logic        headValid;
  logic        startPulse;
  logic        stepPulse;
  dir_e        dirReg;
  logic        obstacleEnReg;

  assign writeFire   = awvalid && awready && wvalid && wready;
  assign readFire    = arvalid && arready;
  assign writeMapped = awaddr inside {`REG_CTRL, `REG_STATUS, `REG_HEAD,
                                      `REG_APPLE, `REG_OBSTACLE, `REG_SCORE};
  // head only means something once a game has started
  assign headValid   = (ctrl.state != stateIdle);

  assign ctrl.start      = startPulse;
  assign ctrl.step       = stepPulse;
  assign ctrl.dir        = dirReg;
  assign ctrl.obstacleEn = obstacleEnReg;

  // read word select
  always_comb begin
    readMapped = 1'b1;
    readWord   = '0;
    case (araddr)
      `REG_CTRL:     readWord = {27'd0, obstacleEnReg, dirReg, 2'b00};
      `REG_STATUS:   readWord = {8'd0, ctrl.stepCount, 2'b00, ctrl.length, 6'd0, ctrl.state};
      `REG_HEAD:     readWord = {23'd0, headValid, ctrl.head};
      `REG_APPLE:    readWord = {23'd0, ctrl.appleValid, ctrl.apple};
      `REG_OBSTACLE: readWord = {23'd0, ctrl.obstacleValid, ctrl.obstacle};
      `REG_SCORE:    readWord = {20'd0, ctrl.bcdScore};
      default:       readMapped = 1'b0;
    endcase
  end

  // handshakes and CTRL fields
  always_ff @(posedge hwclk) begin
    if (rst) begin
      awready       <= 1'b0;
      wready        <= 1'b0;
      bvalid        <= 1'b0;
      arready       <= 1'b0;
      rvalid        <= 1'b0;
      startPulse    <= 1'b0;
      stepPulse     <= 1'b0;
      dirReg        <= dirUp;
      obstacleEnReg <= 1'b0;
    end else begin
      awready    <= 1'b0;
      wready     <= 1'b0;
      arready    <= 1'b0;
      startPulse <= 1'b0;
      stepPulse  <= 1'b0;
      // accept only with address and data both present and no response pending
      if (!awready && awvalid && wvalid && !bvalid) begin
        awready <= 1'b1;
        wready  <= 1'b1;
      end
      if (writeFire) begin
        bvalid <= 1'b1;
        if (awaddr == `REG_CTRL && wstrb[0]) begin
          startPulse    <= wdata[0];
          stepPulse     <= wdata[1];
          dirReg        <= dir_e'(wdata[3:2]);
          obstacleEnReg <= wdata[4];
        end
      end else if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
      if (!arready && arvalid && !rvalid) begin
        arready <= 1'b1;
      end
      if (readFire) begin
        rvalid <= 1'b1;
      end else if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  // response payload
  always_ff @(posedge hwclk) begin
    if (writeFire) begin
      bresp <= writeMapped ? respOkay : respSlvErr;
    end
    if (readFire) begin
      rdata <= readWord;
      rresp <= readMapped ? respOkay : respSlvErr;
    end
  end

  // write response held under back-pressure
  assert property (@(posedge hwclk) disable iff (rst) bvalid && !bready |=> bvalid);

endmodule

`default_nettype wire

// File: source/snake_body_controller.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// snake body as a shift register of cells
// moves the head one cell per step while playing and grows on eat
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "snake_defines.svh"

module snake_body_controller import snake_pkg::*; (
  input  logic       hwclk,
  input  logic       rst,
  gameCtrlIf.body    ctrl,
  input  logic       grow,
  output bodyArray_t body
);

  localparam cell_t startHead = '{x: 4'(`START_X), y: 4'(`START_Y)};
  localparam cell_t startMid  = '{x: 4'(`START_X - 1), y: 4'(`START_Y)};
  localparam cell_t startTail = '{x: 4'(`START_X - 2), y: 4'(`START_Y)};

  bodyArray_t segments;
  logic [5:0] lengthReg;
  logic       movedReg;
  logic       moveNow;
  dir_e       curDir;
  dir_e       nextDir;
  cell_t      nextHead;

  function automatic logic isReverse(dir_e req, dir_e cur);
    case (req)
      dirUp:    return cur == dirDown;
      dirDown:  return cur == dirUp;
      dirLeft:  return cur == dirRight;
      default:  return cur == dirLeft;
    endcase
  endfunction

  assign moveNow = ctrl.step && (ctrl.state == statePlaying);
  // a reversal request keeps the current heading
  assign nextDir = isReverse(ctrl.dir, curDir) ? curDir : ctrl.dir;

  // one cell ahead of the head
  always_comb begin
    nextHead = segments[0];
    case (nextDir)
      dirUp:    nextHead.y = segments[0].y - 4'd1;
      dirDown:  nextHead.y = segments[0].y + 4'd1;
      dirLeft:  nextHead.x = segments[0].x - 4'd1;
      default:  nextHead.x = segments[0].x + 4'd1;
    endcase
  end

  always_ff @(posedge hwclk) begin
    if (rst) begin
      lengthReg <= '0;
      movedReg  <= 1'b0;
      curDir    <= dirRight;
    end else begin
      movedReg <= 1'b0;
      if (ctrl.start) begin
        lengthReg <= 6'd3;
        curDir    <= dirRight;
      end else begin
        if (moveNow) begin
          curDir   <= nextDir;
          movedReg <= 1'b1;
        end
        // old tail is still in the array one slot past the length
        if (grow) begin
          lengthReg <= lengthReg + 6'd1;
        end
      end
    end
  end

  // segment storage
  always_ff @(posedge hwclk) begin
    if (ctrl.start) begin
      segments[0] <= startHead;
      segments[1] <= startMid;
      segments[2] <= startTail;
    end else if (moveNow) begin
      segments <= {segments[`MAX_LENGTH-2:0], nextHead};
    end
  end

  assign body        = segments;
  assign ctrl.head   = segments[0];
  assign ctrl.length = lengthReg;
  assign ctrl.moved  = movedReg;

  // judge stops eating at full length
  assert property (@(posedge hwclk) disable iff (rst) lengthReg <= `MAX_LENGTH);

endmodule

`default_nettype wire

// File: source/apple_placer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// apple and obstacle placement
// free-running LFSR feeds candidates, rejected ones cost one cycle each
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "snake_defines.svh"

module apple_placer import snake_pkg::*; (
  input  logic       hwclk,
  input  logic       rst,
  gameCtrlIf.placer  ctrl,
  input  bodyArray_t body
);

  typedef enum logic [1:0] {searchIdle, searchApple, searchObstacle} search_e;

  search_e     mode;
  logic [15:0] lfsr;
  cell_t       candidate;
  cell_t       appleReg;
  cell_t       obstacleReg;
  logic        appleValidReg;
  logic        obstacleValidReg;
  logic        obstaclePending;
  logic        onBody;
  logic        rejected;
  logic        accept;

  // border coordinates pulled one cell inward
  function automatic logic [3:0] foldCoord(logic [3:0] c);
    if (c == 4'd0) return 4'd1;
    if (c == 4'(`GRID_MAX)) return 4'(`GRID_MAX - 1);
    return c;
  endfunction

  // galois LFSR taps 16 14 13 11
  always_ff @(posedge hwclk) begin
    if (rst) lfsr <= 16'hACE1;
    else lfsr <= {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hB400 : 16'h0000);
  end

  assign candidate.x = foldCoord(lfsr[7:4]);
  assign candidate.y = foldCoord(lfsr[3:0]);

  // occupied segments only
  always_comb begin
    onBody = 1'b0;
    for (int i = 0; i < `MAX_LENGTH; i++) begin
      if (i < int'(ctrl.length) && body[i] == candidate) onBody = 1'b1;
    end
  end

  assign rejected = onBody || (obstacleValidReg && candidate == obstacleReg) ||
                    (mode == searchObstacle && candidate == appleReg);
  assign accept   = !rejected && !ctrl.start && !ctrl.eat;

  always_ff @(posedge hwclk) begin
    if (rst || ctrl.start) begin
      mode             <= rst ? searchIdle : searchApple;
      appleValidReg    <= 1'b0;
      obstacleValidReg <= 1'b0;
      obstaclePending  <= 1'b0;
    end else if (ctrl.eat) begin
      mode            <= searchApple;
      appleValidReg   <= 1'b0;
      obstaclePending <= ctrl.obstacleEn;
    end else if (mode == searchApple && accept) begin
      appleValidReg <= 1'b1;
      // obstacle moves after the apple when enabled
      mode          <= obstaclePending ? searchObstacle : searchIdle;
      if (obstaclePending) obstacleValidReg <= 1'b0;
    end else if (mode == searchObstacle && accept) begin
      obstacleValidReg <= 1'b1;
      obstaclePending  <= 1'b0;
      mode             <= searchIdle;
    end
  end

  always_ff @(posedge hwclk) begin
    if (mode == searchApple && accept) appleReg <= candidate;
    if (mode == searchObstacle && accept) obstacleReg <= candidate;
  end

  assign ctrl.apple         = appleReg;
  assign ctrl.appleValid    = appleValidReg;
  assign ctrl.obstacle      = obstacleReg;
  assign ctrl.obstacleValid = obstacleValidReg;

  assert property (@(posedge hwclk) disable iff (rst)
    appleValidReg |-> appleReg.x != 4'd0 && appleReg.x != 4'(`GRID_MAX) &&
                      appleReg.y != 4'd0 && appleReg.y != 4'(`GRID_MAX));

endmodule

`default_nettype wire

// File: source/game_judge.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// game FSM with collision checks, step counter and BCD score
// judges each move one cycle after the body reports it
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "snake_defines.svh"

module game_judge import snake_pkg::*; (
  input  logic       hwclk,
  input  logic       rst,
  gameCtrlIf.judge   ctrl,
  input  bodyArray_t body
);

  gameState_e      stateReg;
  logic [7:0]      stepCountReg;
  logic            eatReg;
  logic [2:0][3:0] scoreReg;
  logic            onBorder;
  logic            hitObstacle;
  logic            hitBody;
  logic            onApple;

  // ones digit first, carry ripples up
  function automatic logic [2:0][3:0] bcdIncrement(logic [2:0][3:0] digits);
    logic [2:0][3:0] result;
    logic            carry;
    result = digits;
    carry  = 1'b1;
    for (int d = 0; d < 3; d++) begin
      if (carry && result[d] == 4'd9) begin
        result[d] = 4'd0;
      end else if (carry) begin
        result[d] = result[d] + 4'd1;
        carry     = 1'b0;
      end
    end
    return result;
  endfunction

  assign onBorder    = ctrl.head.x == 4'd0 || ctrl.head.x == 4'(`GRID_MAX) ||
                       ctrl.head.y == 4'd0 || ctrl.head.y == 4'(`GRID_MAX);
  assign hitObstacle = ctrl.obstacleValid && ctrl.head == ctrl.obstacle;
  assign onApple     = ctrl.appleValid && ctrl.head == ctrl.apple;

  // segments behind the head
  always_comb begin
    hitBody = 1'b0;
    for (int i = 1; i < `MAX_LENGTH; i++) begin
      if (i < int'(ctrl.length) && body[i] == ctrl.head) hitBody = 1'b1;
    end
  end

  always_ff @(posedge hwclk) begin
    if (rst) begin
      stateReg     <= stateIdle;
      stepCountReg <= '0;
      eatReg       <= 1'b0;
      scoreReg     <= '0;
    end else begin
      eatReg <= 1'b0;
      if (ctrl.start) begin
        stateReg     <= statePlaying;
        stepCountReg <= '0;
        scoreReg     <= '0;
      end else if (ctrl.moved && stateReg == statePlaying) begin
        stepCountReg <= stepCountReg + 8'd1;
        // fatal hits win over the apple
        if (onBorder || hitObstacle || hitBody) begin
          stateReg <= stateOver;
        end else if (onApple) begin
          eatReg   <= 1'b1;
          scoreReg <= bcdIncrement(scoreReg);
          if (int'(ctrl.length) + 1 == `MAX_LENGTH) stateReg <= stateWon;
        end
      end
    end
  end

  assign ctrl.state     = stateReg;
  assign ctrl.stepCount = stepCountReg;
  assign ctrl.eat       = eatReg;
  assign ctrl.bcdScore  = scoreReg;

endmodule

`default_nettype wire

// File: source/snake_game_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// snake game core with an AXI4-Lite control port
// the game advances one cell per bus-issued step
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module snake_game_top import snake_pkg::*; (
  input  logic        hwclk,
  input  logic        rst,
  input  logic [7:0]  awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  input  logic [7:0]  araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready
);

  gameCtrlIf  ctrlIf ();
  // shared snapshot of all segments
  bodyArray_t snakeBody;

  axil_game_regs regs (
    .hwclk(hwclk), .rst(rst),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .ctrl(ctrlIf.regs)
  );

  // eat pulse from the judge doubles as the grow request
  snake_body_controller bodyCtrl (
    .hwclk(hwclk), .rst(rst), .ctrl(ctrlIf.body), .grow(ctrlIf.eat), .body(snakeBody)
  );

  apple_placer placer (.hwclk(hwclk), .rst(rst), .ctrl(ctrlIf.placer), .body(snakeBody));

  game_judge judge (.hwclk(hwclk), .rst(rst), .ctrl(ctrlIf.judge), .body(snakeBody));

endmodule

`default_nettype wire

// File: bench/snake_game_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the AXI4-Lite snake game core
// drives a bus master, keeps a reference snake model and walks a move
// table, then eats apples, hits the wall and hits an obstacle
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "snake_defines.svh"

module snake_game_tb import snake_pkg::*; ();

  localparam int waitLimit = 200;
  localparam int pollLimit = 100;

  typedef struct packed {
    dir_e       dir;
    cell_t      head;
    logic [5:0] len;
    gameState_e state;
    logic [11:0] score;
  } moveEntry_t;

  // requested direction, head xy, length, state, score
  // entries 2 and 4 ask for a reversal and keep the old heading
  localparam moveEntry_t moveTable [6] = '{
    '{dirRight, 8'h58, 6'd3, statePlaying, 12'h000},
    '{dirUp,    8'h57, 6'd3, statePlaying, 12'h000},
    '{dirDown,  8'h56, 6'd3, statePlaying, 12'h000},
    '{dirLeft,  8'h46, 6'd3, statePlaying, 12'h000},
    '{dirRight, 8'h36, 6'd3, statePlaying, 12'h000},
    '{dirDown,  8'h37, 6'd3, statePlaying, 12'h000}
  };

  logic        hwclk;
  logic        rst;
  logic [7:0]  awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [7:0]  araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;

  // reference model of the game
  cell_t      modelBody [$];
  dir_e       modelDir;
  gameState_e modelState;
  int         modelScore;
  cell_t      appleCell;
  cell_t      obstacleCell;
  logic       appleOk;
  logic       obstacleOk;
  logic       obstacleMode;
  logic       ateLast;
  logic [7:0] lastStepCount;
  logic [7:0] lfsrState;

  snake_game_top snake_game_top_inst (.*);

  initial hwclk = 1'b0;
  always #4 hwclk = ~hwclk;

  // galois form, x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsrNext(logic [7:0] s);
    return {1'b0, s[7:1]} ^ (s[0] ? 8'hB8 : 8'h00);
  endfunction

  function automatic int randomBits(int count);
    int value;
    value = 0;
    for (int i = 0; i < count; i++) begin
      lfsrState = lfsrNext(lfsrState);
      value = (value << 1) | int'(lfsrState[0]);
    end
    return value;
  endfunction

  task automatic failRun(input string why);
    $display("Error at %0t ns: %s", $time, why);
    $display("tests failed");
    $fatal(1, "run aborted");
  endtask

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
    if (got !== expected) begin
      $display("Mismatch at %0t ns: %s read 0x%0h, expected 0x%0h", $time, name, got, expected);
      $display("tests failed");
      $fatal(1, "first error stops the run");
    end
  endtask

  task automatic idleGap();
    repeat (randomBits(2)) @(negedge hwclk);
  endtask

  task automatic axiWrite(input logic [7:0] addr, input logic [31:0] data,
                          output logic [1:0] resp);
    int cycles;
    idleGap();
    awaddr  = addr;
    wdata   = data;
    wstrb   = 4'hF;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    cycles  = 0;
    // ready seen here means the transfer lands on the next rising edge
    do begin
      @(negedge hwclk);
      cycles++;
      if (cycles > waitLimit) failRun("write address and data were never accepted");
    end while (!(awready && wready));
    @(negedge hwclk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    cycles  = 0;
    while (!bvalid) begin
      @(negedge hwclk);
      cycles++;
      if (cycles > waitLimit) failRun("no write response arrived");
    end
    resp = bresp;
    // random back-pressure on the response
    repeat (randomBits(2)) @(negedge hwclk);
    bready = 1'b1;
    @(negedge hwclk);
    bready = 1'b0;
  endtask

  task automatic axiRead(input logic [7:0] addr, output logic [31:0] data,
                         output logic [1:0] resp);
    int cycles;
    idleGap();
    araddr  = addr;
    arvalid = 1'b1;
    cycles  = 0;
    do begin
      @(negedge hwclk);
      cycles++;
      if (cycles > waitLimit) failRun("read address was never accepted");
    end while (!arready);
    @(negedge hwclk);
    arvalid = 1'b0;
    cycles  = 0;
    while (!rvalid) begin
      @(negedge hwclk);
      cycles++;
      if (cycles > waitLimit) failRun("no read data arrived");
    end
    data = rdata;
    resp = rresp;
    repeat (randomBits(2)) @(negedge hwclk);
    rready = 1'b1;
    @(negedge hwclk);
    rready = 1'b0;
  endtask

  task automatic readOkay(input logic [7:0] addr, output logic [31:0] data);
    logic [1:0] resp;
    axiRead(addr, data, resp);
    checkValue("rresp", resp, 2'b00);
  endtask

  // CTRL word: start, step, direction, obstacle enable
  task automatic writeCtrl(input logic startBit, input logic stepBit, input dir_e d);
    logic [1:0] resp;
    axiWrite(`REG_CTRL, {27'd0, obstacleMode, d, stepBit, startBit}, resp);
    checkValue("bresp", resp, 2'b00);
  endtask

  function automatic logic [11:0] bcdOf(int value);
    return {4'(value / 100 % 10), 4'(value / 10 % 10), 4'(value % 10)};
  endfunction

  function automatic logic isOpposite(dir_e a, dir_e b);
    return (a == dirUp && b == dirDown) || (a == dirDown && b == dirUp) ||
           (a == dirLeft && b == dirRight) || (a == dirRight && b == dirLeft);
  endfunction

  // up means a smaller y
  function automatic cell_t stepCell(cell_t c, dir_e d);
    cell_t n;
    n = c;
    case (d)
      dirUp:    n.y = c.y - 4'd1;
      dirDown:  n.y = c.y + 4'd1;
      dirLeft:  n.x = c.x - 4'd1;
      default:  n.x = c.x + 4'd1;
    endcase
    return n;
  endfunction

  function automatic logic onBorderCell(cell_t c);
    return c.x == 4'd0 || c.x == 4'(`GRID_MAX) || c.y == 4'd0 || c.y == 4'(`GRID_MAX);
  endfunction

  function automatic logic onModelBody(cell_t c);
    foreach (modelBody[i]) begin
      if (modelBody[i] == c) return 1'b1;
    end
    return 1'b0;
  endfunction

  function automatic logic blockedCell(cell_t c, logic avoidApple);
    return onBorderCell(c) || onModelBody(c) || (obstacleOk && c == obstacleCell) ||
           (avoidApple && appleOk && c == appleCell);
  endfunction

  function automatic int distance(cell_t a, cell_t b);
    int dx;
    int dy;
    dx = int'(a.x) - int'(b.x);
    dy = int'(a.y) - int'(b.y);
    return (dx < 0 ? -dx : dx) + (dy < 0 ? -dy : dy);
  endfunction

  // greedy steering, closer moves first, any safe move second
  function automatic dir_e chooseDir(cell_t target, logic avoidApple);
    dir_e  d;
    cell_t nc;
    for (int pass = 0; pass < 2; pass++) begin
      for (int k = 0; k < 4; k++) begin
        d  = dir_e'(k);
        nc = stepCell(modelBody[0], d);
        if (!isOpposite(d, modelDir) && (nc == target || !blockedCell(nc, avoidApple)) &&
            (pass == 1 || distance(nc, target) < distance(modelBody[0], target))) begin
          return d;
        end
      end
    end
    return modelDir;
  endfunction

  function automatic logic appleOnPath();
    foreach (moveTable[k]) begin
      if (moveTable[k].head == appleCell) return 1'b1;
    end
    return 1'b0;
  endfunction

  task automatic applyModelMove(input dir_e want);
    dir_e  heading;
    cell_t newHead;
    logic  crash;
    heading = isOpposite(want, modelDir) ? modelDir : want;
    newHead = stepCell(modelBody[0], heading);
    crash   = onBorderCell(newHead) || (obstacleOk && newHead == obstacleCell);
    // segments that trail the head once the body has shifted
    for (int i = 0; i < modelBody.size() - 1; i++) begin
      if (modelBody[i] == newHead) crash = 1'b1;
    end
    modelDir = heading;
    ateLast  = 1'b0;
    modelBody.push_front(newHead);
    if (crash) begin
      modelState = stateOver;
      void'(modelBody.pop_back());
    end else if (appleOk && newHead == appleCell) begin
      // tail stays, so the snake grows by one
      ateLast    = 1'b1;
      appleOk    = 1'b0;
      modelScore = modelScore + 1;
      if (obstacleMode) obstacleOk = 1'b0;
      if (modelBody.size() == `MAX_LENGTH) modelState = stateWon;
    end else begin
      void'(modelBody.pop_back());
    end
  endtask

  task automatic waitStepDone();
    logic [31:0] status;
    logic [7:0]  expCount;
    int          polls;
    polls    = 0;
    expCount = lastStepCount + 8'd1;
    do begin
      readOkay(`REG_STATUS, status);
      polls++;
      if (polls > pollLimit) failRun("stepCount never advanced after a step");
    end while (status[23:16] == lastStepCount);
    checkValue("STATUS.stepCount", status[23:16], expCount);
    lastStepCount = status[23:16];
  endtask

  task automatic checkState(input cell_t expHead, input int expLen,
                            input gameState_e expState, input logic [11:0] expScore);
    logic [31:0] word;
    readOkay(`REG_STATUS, word);
    checkValue("STATUS.state", word[1:0], expState);
    checkValue("STATUS.length", word[13:8], expLen);
    readOkay(`REG_HEAD, word);
    checkValue("HEAD.valid", word[8], 1);
    checkValue("HEAD.cell", word[7:0], expHead);
    readOkay(`REG_SCORE, word);
    checkValue("SCORE", word[11:0], expScore);
  endtask

  task automatic checkModel();
    checkState(modelBody[0], modelBody.size(), modelState, bcdOf(modelScore));
  endtask

  task automatic waitApple();
    logic [31:0] word;
    int          polls;
    polls = 0;
    do begin
      readOkay(`REG_APPLE, word);
      polls++;
      if (polls > pollLimit) failRun("apple never became valid");
    end while (!word[8]);
    appleCell = word[7:0];
    appleOk   = 1'b1;
    checkValue("APPLE.inside", !onBorderCell(appleCell), 1);
    checkValue("APPLE.offBody", onModelBody(appleCell), 0);
  endtask

  task automatic waitObstacle();
    logic [31:0] word;
    int          polls;
    polls = 0;
    do begin
      readOkay(`REG_OBSTACLE, word);
      polls++;
      if (polls > pollLimit) failRun("obstacle never became valid");
    end while (!word[8]);
    obstacleCell = word[7:0];
    obstacleOk   = 1'b1;
    checkValue("OBSTACLE.inside", !onBorderCell(obstacleCell), 1);
    checkValue("OBSTACLE.offApple", obstacleCell == appleCell, 0);
    checkValue("OBSTACLE.offBody", onModelBody(obstacleCell), 0);
  endtask

  task automatic doStep(input dir_e want);
    applyModelMove(want);
    writeCtrl(1'b0, 1'b1, want);
    waitStepDone();
  endtask

  task automatic moveAndCheck(input dir_e want);
    doStep(want);
    checkModel();
    if (ateLast) begin
      waitApple();
      if (obstacleMode) waitObstacle();
    end
  endtask

  task automatic steerTo(input cell_t target, input logic avoidApple);
    int steps;
    steps = 0;
    while (modelBody[0] != target) begin
      if (modelState != statePlaying) failRun("snake died before reaching its target");
      steps++;
      if (steps > 100) failRun("snake did not reach its target");
      moveAndCheck(chooseDir(target, avoidApple));
    end
  endtask

  task automatic startGame(input logic withObstacle);
    cell_t c;
    obstacleMode = withObstacle;
    writeCtrl(1'b1, 1'b0, dirRight);
    // head at the start cell, two segments trailing to the left
    modelBody.delete();
    for (int i = 0; i < 3; i++) begin
      c.x = 4'(`START_X - i);
      c.y = 4'(`START_Y);
      modelBody.push_back(c);
    end
    modelDir      = dirRight;
    modelState    = statePlaying;
    modelScore    = 0;
    appleOk       = 1'b0;
    obstacleOk    = 1'b0;
    ateLast       = 1'b0;
    lastStepCount = 8'd0;
    waitApple();
    checkModel();
  endtask

  task automatic expectOver();
    logic [31:0] word;
    readOkay(`REG_STATUS, word);
    checkValue("STATUS.state", word[1:0], stateOver);
  endtask

  initial begin
    logic [31:0] word;
    logic [31:0] headBefore;
    logic [1:0]  resp;
    int          attempt;
    int          steps;
    rst          = 1'b1;
    awaddr       = '0;
    awvalid      = 1'b0;
    wdata        = '0;
    wstrb        = '0;
    wvalid       = 1'b0;
    bready       = 1'b0;
    araddr       = '0;
    arvalid      = 1'b0;
    rready       = 1'b0;
    lfsrState    = 8'd84;
    obstacleMode = 1'b0;
    obstacleOk   = 1'b0;
    appleOk      = 1'b0;
    repeat (2) @(negedge hwclk);
    rst = 1'b0;

    // idle after reset, control and status words all read zero
    readOkay(`REG_CTRL, word);
    checkValue("CTRL", word, 32'd0);
    readOkay(`REG_STATUS, word);
    checkValue("STATUS", word, 32'd0);
    readOkay(`REG_SCORE, word);
    checkValue("SCORE", word, 32'd0);
    axiRead(8'h18, word, resp);
    checkValue("rresp unmapped", resp, 2'b10);

    // restart until the apple is clear of the table path
    attempt = 0;
    do begin
      attempt++;
      if (attempt > 8) failRun("apple kept landing on the move table path");
      startGame(1'b0);
    end while (appleOnPath());

    foreach (moveTable[k]) begin
      doStep(moveTable[k].dir);
      checkState(moveTable[k].head, moveTable[k].len, moveTable[k].state, moveTable[k].score);
    end

    // two apples
    repeat (2) steerTo(appleCell, 1'b0);

    // straight ahead into the border
    steps = 0;
    while (modelState == statePlaying) begin
      steps++;
      if (steps > 20) failRun("snake never reached the border");
      moveAndCheck(modelDir);
    end
    expectOver();
    readOkay(`REG_HEAD, headBefore);
    writeCtrl(1'b0, 1'b1, modelDir);
    // a step after game over must change nothing
    repeat (10) @(negedge hwclk);
    readOkay(`REG_STATUS, word);
    checkValue("STATUS.stepCount", word[23:16], lastStepCount);
    checkValue("STATUS.state", word[1:0], stateOver);
    readOkay(`REG_HEAD, word);
    checkValue("HEAD", word, headBefore);

    // obstacle game, one apple then into the obstacle
    startGame(1'b1);
    steerTo(appleCell, 1'b0);
    steerTo(obstacleCell, 1'b1);
    expectOver();

    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+include
source/snake_pkg.sv
source/game_ctrl_if.sv
source/axil_game_regs.sv
source/snake_body_controller.sv
source/apple_placer.sv
source/game_judge.sv
source/snake_game_top.sv
bench/snake_game_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the snake core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module snake_game_tb -o snake_sim

./obj_dir/snake_sim | tee sim.log

if grep -q "all tests passed" sim.log; then
  exit 0
fi
exit 1
